/* logic/harness_pkg.sv */
`default_nettype none

package harness_pkg;

	// ========================================
	// Widths
	// ========================================
	localparam int adr_width     = 16;
	localparam int byte_width    = 8;
	localparam int atom_width    = 32;
	localparam int num_routes    = 4;
	localparam int snap_width    = 30;
	localparam int dut_adr_width = 15;

	// Decoded regions of the host register window.
	typedef enum logic [2:0] {
		reg_none,
		reg_led0,
		reg_led1,
		reg_atom,
		reg_ones,
		reg_pa,
		reg_dut,
		reg_irq
	} region_t;

	// ========================================
	// Register map
	// ========================================
	localparam logic [adr_width-1:0] adr_led0 = 16'hff00;
	localparam logic [adr_width-1:0] adr_led1 = 16'hff01;
	localparam logic [adr_width-1:0] adr_atom = 16'hff10; // Four bytes.
	localparam logic [adr_width-1:0] adr_ones = 16'hff14;
	localparam logic [adr_width-1:0] adr_pa   = 16'hff40; // Four bytes.
	localparam logic [adr_width-1:0] adr_dut  = 16'hff50; // Four bytes.
	localparam logic [adr_width-1:0] adr_irq  = 16'hfffe;

	// Bits of the DUT control byte at offset 0.
	localparam int ctl_reset_on  = 0;
	localparam int ctl_ovr_on    = 1;
	localparam int ctl_reset_off = 2;
	localparam int ctl_ovr_off   = 3;

endpackage

`default_nettype wire

/* logic/host_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module host_regs (
	input  wire                                    cpuclk,
	input  wire                                    f_reset,
	input  wire  [harness_pkg::adr_width-1:0]      adr,
	input  wire  [harness_pkg::byte_width-1:0]     wdata,
	input  wire                                    wr,
	input  wire  [harness_pkg::byte_width-1:0]     pa_rdata,
	input  wire  [harness_pkg::snap_width-1:0]     snapshot,
	input  wire  [harness_pkg::byte_width-1:0]     irq_flags,
	output logic [harness_pkg::byte_width-1:0]     rdata,
	output logic [2*harness_pkg::byte_width-1:0]   led,
	output logic [harness_pkg::atom_width-1:0]     atom,
	output wire  [1:0]                             sub,
	output wire                                    pa_wr,
	output wire                                    dut_wr,
	output wire                                    ones_wr,
	output wire                                    irq_wr
);

	harness_pkg::region_t region;
	logic                 r_pa_held;
	logic                 r_dut_held;

	// ========================================
	// Address decode
	// ========================================
	always_comb begin
		region = harness_pkg::reg_none;
		if (adr == harness_pkg::adr_led0)
			region = harness_pkg::reg_led0;
		else if (adr == harness_pkg::adr_led1)
			region = harness_pkg::reg_led1;
		else if (adr[harness_pkg::adr_width-1:2] == harness_pkg::adr_atom[harness_pkg::adr_width-1:2])
			region = harness_pkg::reg_atom;
		else if (adr == harness_pkg::adr_ones)
			region = harness_pkg::reg_ones;
		else if (adr[harness_pkg::adr_width-1:2] == harness_pkg::adr_pa[harness_pkg::adr_width-1:2])
			region = harness_pkg::reg_pa;
		else if (adr[harness_pkg::adr_width-1:2] == harness_pkg::adr_dut[harness_pkg::adr_width-1:2])
			region = harness_pkg::reg_dut;
		else if (adr == harness_pkg::adr_irq)
			region = harness_pkg::reg_irq;
	end

	assign sub = adr[1:0];

	// Port A and DUT writes fire once per held write strobe.
	assign pa_wr   = wr && region == harness_pkg::reg_pa && !r_pa_held;
	assign dut_wr  = wr && region == harness_pkg::reg_dut && !r_dut_held;
	assign ones_wr = wr && region == harness_pkg::reg_ones;
	assign irq_wr  = wr && region == harness_pkg::reg_irq;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			r_pa_held  <= 1'b0;
			r_dut_held <= 1'b0;
			led        <= '0;
		end else begin
			r_pa_held  <= wr && region == harness_pkg::reg_pa;
			r_dut_held <= wr && region == harness_pkg::reg_dut;
			if (wr && region == harness_pkg::reg_led0)
				led[harness_pkg::byte_width-1:0] <= wdata;
			if (wr && region == harness_pkg::reg_led1)
				led[2*harness_pkg::byte_width-1:harness_pkg::byte_width] <= wdata;
		end
	end

	always_ff @(posedge cpuclk) begin
		if (wr && region == harness_pkg::reg_atom)
			atom[sub*harness_pkg::byte_width +: harness_pkg::byte_width] <= wdata;
	end

	// ========================================
	// Read-back
	// ========================================
	always_comb begin
		rdata = '1; // Unmapped space reads as all ones.
		case (region)
		harness_pkg::reg_led0: rdata = led[harness_pkg::byte_width-1:0];
		harness_pkg::reg_led1: rdata = led[2*harness_pkg::byte_width-1:harness_pkg::byte_width];
		harness_pkg::reg_atom: rdata = atom[sub*harness_pkg::byte_width +: harness_pkg::byte_width];
		harness_pkg::reg_pa:   if (sub == 2'd0) rdata = pa_rdata;
		harness_pkg::reg_dut:
			case (sub)
			2'd0: rdata = snapshot[7:0];
			2'd1: rdata = snapshot[15:8];
			2'd2: rdata = snapshot[23:16];
			default: rdata = {2'b00, snapshot[29:24]}; // Top byte is only six bits wide.
			endcase
		harness_pkg::reg_irq:  rdata = irq_flags;
		default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/port_a.sv */
`timescale 1ns/100ps
`default_nettype none

module port_a (
	input  wire                                 cpuclk,
	input  wire                                 f_reset,
	input  wire                                 pa_wr,
	input  wire  [1:0]                          sub,
	input  wire  [harness_pkg::byte_width-1:0]  wdata,
	input  wire  [harness_pkg::atom_width-1:0]  atom,
	input  wire  [harness_pkg::num_routes-1:0]  route,
	output logic [harness_pkg::byte_width-1:0]  pa_out,
	output wire  [harness_pkg::byte_width-1:0]  pa_rdata
);

	logic [harness_pkg::num_routes-1:0] set_route;
	logic [harness_pkg::num_routes-1:0] clr_route;
	logic [harness_pkg::byte_width-1:0] set_mask;
	logic [harness_pkg::byte_width-1:0] clr_mask;

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (pa_wr && sub == 2'd0)
			set_mask = wdata;
		if (pa_wr && sub == 2'd1)
			clr_mask = wdata;

		// Any armed route pulses bit 0.
		set_mask[0] = set_mask[0] | (|(set_route & route));
		clr_mask[0] = clr_mask[0] | (|(clr_route & route));
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			pa_out    <= '0;
			set_route <= '0;
			clr_route <= '0;
		end else begin
			pa_out <= (pa_out | set_mask) & ~clr_mask; // Clear wins over set.
			if (pa_wr && sub == 2'd2 && wdata == 8'h01)
				set_route <= atom[harness_pkg::num_routes-1:0];
			if (pa_wr && sub == 2'd3 && wdata == 8'h01)
				clr_route <= atom[harness_pkg::num_routes-1:0];
		end
	end

	assign pa_rdata = pa_out;

endmodule

`default_nettype wire

/* logic/dut_bus_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module dut_bus_driver (
	input  wire                                    cpuclk,
	input  wire                                    f_reset,
	input  wire                                    dut_wr,
	input  wire  [1:0]                             sub,
	input  wire  [harness_pkg::byte_width-1:0]     wdata,
	input  wire  [harness_pkg::dut_adr_width-1:0]  dut_adr,
	input  wire                                    rd_act,
	input  wire                                    cs_rom_act,
	input  wire                                    cs_xram_act,
	output wire  [harness_pkg::byte_width-1:0]     dut_data_out,
	output logic                                   dut_data_oe,
	output logic                                   sdir,
	output wire                                    n_soe,
	output logic                                   dut_reset_drive
);

	logic                               r_rd;
	logic                               r_any_cs;
	logic                               any_cs;
	logic                               rd_active;
	logic                               ctl_wr;
	logic                               ovr_on;
	logic [harness_pkg::byte_width-1:0] ovr_byte;

	// External RAM counts only in the 0xa000 window.
	assign any_cs    = cs_rom_act || (cs_xram_act && dut_adr[13] && !dut_adr[14]);
	assign rd_active = r_rd && r_any_cs;
	assign ctl_wr    = dut_wr && sub == 2'd0;

	// ========================================
	// Direction before enable
	// ========================================
	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			r_rd            <= 1'b0;
			r_any_cs        <= 1'b0;
			sdir            <= 1'b0;
			dut_data_oe     <= 1'b0;
			ovr_on          <= 1'b0;
			dut_reset_drive <= 1'b0;
		end else begin
			r_rd     <= rd_act;
			r_any_cs <= any_cs;
			if (rd_active) begin
				sdir        <= 1'b1;
				dut_data_oe <= sdir; // Enable only once the shifter points outward.
			end else begin
				dut_data_oe <= 1'b0;
				if (!dut_data_oe)
					sdir <= 1'b0;
			end
			ovr_on <= (ovr_on | (ctl_wr & wdata[harness_pkg::ctl_ovr_on]))
			          & ~(ctl_wr & wdata[harness_pkg::ctl_ovr_off]);
			dut_reset_drive <= (dut_reset_drive | (ctl_wr & wdata[harness_pkg::ctl_reset_on]))
			                   & ~(ctl_wr & wdata[harness_pkg::ctl_reset_off]);
		end
	end

	always_ff @(posedge cpuclk) begin
		if (dut_wr && sub == 2'd2)
			ovr_byte <= wdata;
	end

	// The shifter is disabled for the cycle in which the bus turns around.
	assign n_soe        = !(r_any_cs && (rd_active || !dut_data_oe));
	assign dut_data_out = ovr_on ? ovr_byte : '1;

endmodule

`default_nettype wire

/* logic/dut_trigger.sv */
`timescale 1ns/100ps
`default_nettype none

module dut_trigger (
	input  wire                                    cpuclk,
	input  wire                                    f_reset,
	input  wire                                    dut_wr,
	input  wire  [1:0]                             sub,
	input  wire  [harness_pkg::byte_width-1:0]     wdata,
	input  wire  [harness_pkg::atom_width-1:0]     atom,
	input  wire  [harness_pkg::dut_adr_width-1:0]  dut_adr,
	input  wire                                    cs_rom_act,
	input  wire                                    cs_xram_act,
	input  wire                                    rd_act,
	input  wire                                    wr_act,
	input  wire                                    dut_phi,
	input  wire                                    reset_act,
	input  wire  [harness_pkg::byte_width-1:0]     dut_data_in,
	input  wire                                    dut_data_oe,
	output logic [harness_pkg::snap_width-1:0]     snapshot,
	output wire                                    match,
	output logic [harness_pkg::num_routes-1:0]     trig_mask
);

	logic [harness_pkg::snap_width-1:0] cmp_val;
	logic [harness_pkg::snap_width-1:0] cmp_mask;

	// Sampled every cycle, address in the low bits.
	always_ff @(posedge cpuclk) begin
		snapshot <= {reset_act, dut_phi, wr_act, rd_act, cs_xram_act,
		             dut_data_oe, dut_data_in, cs_rom_act, dut_adr};
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			cmp_val   <= '0;
			cmp_mask  <= '0;
			trig_mask <= '0;
		end else begin
			if (dut_wr && sub == 2'd3) begin
				if (wdata[0])
					cmp_val <= atom[harness_pkg::snap_width-1:0];
				if (wdata[1])
					cmp_mask <= atom[harness_pkg::snap_width-1:0];
			end
			if (dut_wr && sub == 2'd1 && wdata[0])
				trig_mask <= atom[harness_pkg::num_routes-1:0];
		end
	end

	assign match = ((snapshot ^ cmp_val) & cmp_mask) == '0;

endmodule

`default_nettype wire

/* logic/route_merge.sv */
`timescale 1ns/100ps
`default_nettype none

module route_merge (
	input  wire                                 cpuclk,
	input  wire                                 f_reset,
	input  wire                                 ones_wr,
	input  wire                                 irq_wr,
	input  wire  [harness_pkg::byte_width-1:0]  wdata,
	input  wire  [harness_pkg::atom_width-1:0]  atom,
	input  wire                                 match,
	input  wire  [harness_pkg::num_routes-1:0]  trig_mask,
	output logic [harness_pkg::num_routes-1:0]  route,
	output logic [harness_pkg::byte_width-1:0]  irq_flags
);

	logic [harness_pkg::num_routes-1:0] ones_mask;
	logic [harness_pkg::byte_width-1:0] irq_clr;

	assign ones_mask = ones_wr ? atom[harness_pkg::num_routes-1:0] : '0; // One cycle only.
	assign irq_clr   = irq_wr ? wdata : '0;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			route     <= '0;
			irq_flags <= '0;
		end else begin
			route     <= ones_mask | (match ? trig_mask : '0);
			irq_flags <= (irq_flags & ~irq_clr)
			             | {{(harness_pkg::byte_width-harness_pkg::num_routes){1'b0}}, route};
		end
	end

endmodule

`default_nettype wire

/* logic/cart_harness.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_harness (
	input  wire                                    cpuclk,
	input  wire                                    f_reset,
	input  wire  [harness_pkg::adr_width-1:0]      adr,
	input  wire  [harness_pkg::byte_width-1:0]     wdata,
	input  wire                                    wr,
	output wire  [harness_pkg::byte_width-1:0]     rdata,
	input  wire  [harness_pkg::dut_adr_width-1:0]  dut_adr,
	input  wire  [harness_pkg::byte_width-1:0]     dut_data_in,
	input  wire                                    n_dut_rd,
	input  wire                                    n_dut_wr,
	input  wire                                    n_dut_cs_rom,
	input  wire                                    n_dut_cs_xram,
	input  wire                                    dut_phi,
	input  wire                                    n_dut_reset,
	output wire  [harness_pkg::byte_width-1:0]     dut_data_out,
	output wire                                    dut_data_oe,
	output wire                                    sdir,
	output wire                                    n_soe,
	output wire                                    dut_reset_drive,
	output wire  [harness_pkg::byte_width-1:0]     pa_out,
	output wire  [2*harness_pkg::byte_width-1:0]   led,
	output wire  [harness_pkg::num_routes-1:0]     route,
	output wire  [harness_pkg::byte_width-1:0]     irq_flags
);

	wire [harness_pkg::atom_width-1:0] atom;
	wire [1:0]                         sub;
	wire                               pa_wr;
	wire                               dut_wr;
	wire                               ones_wr;
	wire                               irq_wr;
	wire [harness_pkg::byte_width-1:0] pa_rdata;
	wire [harness_pkg::snap_width-1:0] snapshot;
	wire                               match;
	wire [harness_pkg::num_routes-1:0] trig_mask;

	// Cartridge strobes are active low on the pins.
	wire rd_act      = !n_dut_rd;
	wire wr_act      = !n_dut_wr;
	wire cs_rom_act  = !n_dut_cs_rom;
	wire cs_xram_act = !n_dut_cs_xram;
	wire reset_act   = !n_dut_reset;

	host_regs u_host_regs (
		.cpuclk, .f_reset, .adr, .wdata, .wr, .pa_rdata, .snapshot, .irq_flags,
		.rdata, .led, .atom, .sub, .pa_wr, .dut_wr, .ones_wr, .irq_wr
	);

	port_a u_port_a (
		.cpuclk, .f_reset, .pa_wr, .sub, .wdata, .atom, .route, .pa_out, .pa_rdata
	);

	dut_bus_driver u_dut_bus_driver (
		.cpuclk, .f_reset, .dut_wr, .sub, .wdata, .dut_adr, .rd_act, .cs_rom_act,
		.cs_xram_act, .dut_data_out, .dut_data_oe, .sdir, .n_soe, .dut_reset_drive
	);

	dut_trigger u_dut_trigger (
		.cpuclk, .f_reset, .dut_wr, .sub, .wdata, .atom, .dut_adr, .cs_rom_act,
		.cs_xram_act, .rd_act, .wr_act, .dut_phi, .reset_act, .dut_data_in,
		.dut_data_oe, .snapshot, .match, .trig_mask
	);

	route_merge u_route_merge (
		.cpuclk, .f_reset, .ones_wr, .irq_wr, .wdata, .atom, .match, .trig_mask,
		.route, .irq_flags
	);

endmodule

`default_nettype wire

/* testbench/cart_harness_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_harness_tb;

	logic                                   cpuclk = 1'b0;
	logic                                   f_reset;
	logic [harness_pkg::adr_width-1:0]      adr;
	logic [harness_pkg::byte_width-1:0]     wdata;
	logic                                   wr;
	wire  [harness_pkg::byte_width-1:0]     rdata;
	logic [harness_pkg::dut_adr_width-1:0]  dut_adr;
	logic [harness_pkg::byte_width-1:0]     dut_data_in;
	logic                                   n_dut_rd;
	logic                                   n_dut_wr;
	logic                                   n_dut_cs_rom;
	logic                                   n_dut_cs_xram;
	logic                                   dut_phi;
	logic                                   n_dut_reset;
	wire  [harness_pkg::byte_width-1:0]     dut_data_out;
	wire                                    dut_data_oe;
	wire                                    sdir;
	wire                                    n_soe;
	wire                                    dut_reset_drive;
	wire  [harness_pkg::byte_width-1:0]     pa_out;
	wire  [2*harness_pkg::byte_width-1:0]   led;
	wire  [harness_pkg::num_routes-1:0]     route;
	wire  [harness_pkg::byte_width-1:0]     irq_flags;

	integer           fd;
	integer           code;
	integer           num_lines = 0;
	integer           error_count = 0;
	logic [7:0]       op;
	logic [31:0]      arg [0:7];
	logic [8*160-1:0] line_buf;
	logic             done;

	logic [harness_pkg::num_routes-1:0] last_route = '0;

	cart_harness DUT (
		.cpuclk, .f_reset, .adr, .wdata, .wr, .rdata, .dut_adr, .dut_data_in, .n_dut_rd,
		.n_dut_wr, .n_dut_cs_rom, .n_dut_cs_xram, .dut_phi, .n_dut_reset, .dut_data_out,
		.dut_data_oe, .sdir, .n_soe, .dut_reset_drive, .pa_out, .led, .route, .irq_flags
	);

	always #10 cpuclk = ~cpuclk; // 20 ns period.

	// ========================================
	// Helpers
	// ========================================
	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
	                           input string what);
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	// One write cycle, then one idle cycle so the next write starts a new strobe.
	task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
		adr   = a;
		wdata = d;
		wr    = 1'b1;
		@(negedge cpuclk);
		wr = 1'b0;
		@(negedge cpuclk);
	endtask

	task automatic read_reg(input logic [15:0] a, input logic [7:0] expected);
		adr = a;
		wr  = 1'b0;
		@(negedge cpuclk);
		check_value(rdata, expected, $sformatf("read of %h", a));
		if (a == harness_pkg::adr_irq)
			check_value(irq_flags, expected, "irq_flags"); // The flag byte is also a port.
	endtask

	task automatic drive_bus(input logic [14:0] a, input logic [7:0] d, input logic rom,
	                         input logic xram, input logic rd, input logic wrs,
	                         input logic phi, input logic rst);
		dut_adr       = a;
		dut_data_in   = d;
		n_dut_cs_rom  = !rom; // Pins are active low.
		n_dut_cs_xram = !xram;
		n_dut_rd      = !rd;
		n_dut_wr      = !wrs;
		dut_phi       = phi;
		n_dut_reset   = !rst;
		@(negedge cpuclk);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		f_reset = 1'b1;
		adr     = '0;
		wdata   = '0;
		wr      = 1'b0;
		drive_bus_idle: begin
			dut_adr       = '0;
			dut_data_in   = '0;
			n_dut_rd      = 1'b1;
			n_dut_wr      = 1'b1;
			n_dut_cs_rom  = 1'b1;
			n_dut_cs_xram = 1'b1;
			dut_phi       = 1'b0;
			n_dut_reset   = 1'b1;
		end

		fd = $fopen("testbench/harness_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the input file testbench/harness_input.txt.");
			$display("Errors found");
			$fatal(1, "Missing input file.");
		end
		while ($fgets(line_buf, fd) > 0)
			num_lines = num_lines + 1; // Sizes the watchdog.
		$fclose(fd);
		fd = $fopen("testbench/harness_input.txt", "r");

		repeat (3) @(posedge cpuclk);
		@(negedge cpuclk);
		f_reset = 1'b0;

		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", op);
			if (code != 1) begin
				done = 1'b1;
			end else begin
				case (op)
				"#": code = $fgets(line_buf, fd);
				"W": begin
					code = $fscanf(fd, "%h %h", arg[0], arg[1]);
					write_reg(arg[0][15:0], arg[1][7:0]);
				end
				"R": begin
					code = $fscanf(fd, "%h %h", arg[0], arg[1]);
					read_reg(arg[0][15:0], arg[1][7:0]);
				end
				"B": begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h %h", arg[0], arg[1], arg[2],
					               arg[3], arg[4], arg[5], arg[6], arg[7]);
					drive_bus(arg[0][14:0], arg[1][7:0], arg[2][0], arg[3][0], arg[4][0],
					          arg[5][0], arg[6][0], arg[7][0]);
				end
				"P": begin
					code = $fscanf(fd, "%h", arg[0]);
					check_value(pa_out, arg[0], "pa_out");
				end
				"L": begin
					code = $fscanf(fd, "%h", arg[0]);
					check_value(led, arg[0], "led");
				end
				"O": begin
					code = $fscanf(fd, "%h %h %h %h %h", arg[0], arg[1], arg[2], arg[3], arg[4]);
					check_value(dut_data_oe, arg[0], "dut_data_oe");
					check_value(sdir, arg[1], "sdir");
					check_value(n_soe, arg[2], "n_soe");
					check_value(dut_reset_drive, arg[3], "dut_reset_drive");
					check_value(dut_data_out, arg[4], "dut_data_out");
				end
				"I": begin
					code = $fscanf(fd, "%d", arg[0]);
					repeat (arg[0]) @(negedge cpuclk);
				end
				default: begin
					$display("The input file holds an unknown operation '%c'.", op);
					$display("Errors found");
					$fatal(1, "Bad input file.");
				end
				endcase
			end
		end
		$fclose(fd);

		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// A route bit must show in the flag byte one cycle after it is seen.
	always @(negedge cpuclk) begin
		check_value(irq_flags[harness_pkg::num_routes-1:0] & last_route, last_route,
		            "irq_flags after route");
		last_route = route;
	end

	// Allows 40 clock cycles for each line of the input file.
	initial begin
		wait (num_lines > 0);
		#(num_lines * 40 * 20);
		$display("Timeout after %0d cycles, the operation list did not finish.", num_lines * 40);
		$display("Errors found");
		$fatal(1, "Watchdog expired.");
	end

endmodule

`default_nettype wire

/* testbench/harness_input.txt */
# W adr data | R adr expected | B dut_adr data rom xram rd wr phi reset | I cycles
# P pa_out | L led | O oe sdir n_soe reset_drive data_out (all values hex)
# LED and unmapped read-back
W ff00 a5
W ff01 3c
L 3ca5
R ff00 a5
R ff01 3c
R 0000 ff
R ff20 ff
# Port A set and clear masks
W ff40 f0
P f0
W ff41 31
P c0
W ff40 0c
R ff40 cc
P cc
# Atom bytes, then compare value 1a5a2155
W ff10 55
W ff11 21
W ff12 5a
W ff13 1a
R ff10 55
R ff11 21
R ff12 5a
R ff13 1a
W ff53 01
# Compare mask 08ff7fff covers address, data and write strobe
W ff10 ff
W ff11 7f
W ff12 ff
W ff13 08
W ff53 02
# Route 1 as trigger route and as Port A set route
W ff10 02
W ff11 00
W ff12 00
W ff13 00
W ff51 01
W ff42 01
# Wrong data byte gives no trigger
B 2155 5b 0 1 0 1 1 0
I 2
P cc
R fffe 00
# Matching pattern
B 2155 5a 0 1 0 1 1 0
I 2
P cd
R fffe 02
B 0000 00 0 0 0 0 0 0
I 2
W fffe 02
R fffe 00
# Ones trigger with routes 0, 2 and 3
W ff10 0d
W ff14 00
R fffe 0d
W fffe 0f
R fffe 00
P cd
# ROM read drives the shifter, then the output enable
B 1234 a7 1 0 1 0 1 0
O 0 0 0 0 ff
I 1
O 0 1 0 0 ff
I 1
O 1 1 0 0 ff
R ff50 34
R ff51 92
R ff52 a7
R ff53 15
# Override byte and reset drive
W ff52 3c
W ff50 02
O 1 1 0 0 3c
W ff50 01
O 1 1 0 1 3c
W ff50 04
O 1 1 0 0 3c
W ff50 08
O 1 1 0 0 ff
# End of read and turnaround
B 0000 00 0 0 0 0 0 0
O 1 1 1 0 ff
I 1
O 0 1 1 0 ff
I 1
O 0 0 1 0 ff
# Snapshot with external RAM, write and reset active
B 4001 c3 0 1 0 1 0 1
R ff50 01
R ff51 40
R ff52 c3
R ff53 2a

/* cart_harness.f */
logic/harness_pkg.sv
logic/host_regs.sv
logic/port_a.sv
logic/dut_bus_driver.sv
logic/dut_trigger.sv
logic/route_merge.sv
logic/cart_harness.sv
testbench/cart_harness_tb.sv

/* Bender.yml */
package:
  name: cart_harness

sources:
  - logic/harness_pkg.sv
  - logic/host_regs.sv
  - logic/port_a.sv
  - logic/dut_bus_driver.sv
  - logic/dut_trigger.sv
  - logic/route_merge.sv
  - logic/cart_harness.sv
  - target: test
    files:
      - testbench/cart_harness_tb.sv
